//--- soc_bus_pkg.sv
/*
 * SoC bus definitions
 * Widths and vector types shared by the request/response bus, the targets
 * and the UART character output
 */

package soc_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth = 64;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned CharWidth = 8;

  // Address bits below the word index
  localparam int unsigned ByteOffsetBits = 3;

  //////////////////////////////////////////////////////////////////////
  // Bus types
  //////////////////////////////////////////////////////////////////////

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [CharWidth-1:0] uart_char_t;

endpackage : soc_bus_pkg

//--- soc_map_pkg.sv
/*
 * SoC memory map
 * Target encoding plus base addresses and region lengths of the L2,
 * UART, control registers and boot ROM
 */

package soc_map_pkg;

  // Bus targets, NONE marks an unmapped address
  typedef enum logic [2:0] {
    L2MEM = 3'd0,
    UART  = 3'd1,
    CTRL  = 3'd2,
    ROM   = 3'd3,
    NONE  = 3'd4
  } soc_target_e;

  //////////////////////////////////////////////////////////////////////
  // Base addresses
  //////////////////////////////////////////////////////////////////////

  localparam logic [63:0] DramBase = 64'h8000_0000;
  localparam logic [63:0] UartBase = 64'h1000_0000;
  localparam logic [63:0] CtrlBase = 64'hD000_0000;
  localparam logic [63:0] RomBase  = 64'h0001_0000;

  // Region lengths in bytes
  localparam logic [63:0] DramLength = 64'h2000;
  localparam logic [63:0] UartLength = 64'h1000;
  localparam logic [63:0] CtrlLength = 64'h1000;
  localparam logic [63:0] RomLength  = 64'h10000;

endpackage : soc_map_pkg

//--- soc_addr_decoder.sv
/*
 * Address decoder
 * Queues credited requests, decodes their target on entry, dispatches the
 * head to one target per cycle and returns responses in request order
 */

module soc_addr_decoder #(
  parameter int unsigned ReqQueueDepth = 4
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_valid_i,
  input  logic               req_we_i,
  input  soc_bus_pkg::addr_t req_addr_i,
  input  soc_bus_pkg::data_t req_wdata_i,
  input  soc_bus_pkg::strb_t req_strb_i,
  output logic               credit_o,
  output logic               rsp_valid_o,
  output soc_bus_pkg::data_t rsp_rdata_o,
  output logic               rsp_err_o,
  output logic               l2_sel_o,
  output logic               uart_sel_o,
  output logic               ctrl_sel_o,
  output logic               rom_sel_o,
  output logic               tgt_we_o,
  output soc_bus_pkg::addr_t tgt_addr_o,
  output soc_bus_pkg::data_t tgt_wdata_o,
  output soc_bus_pkg::strb_t tgt_strb_o,
  input  soc_bus_pkg::data_t l2_rdata_i,
  input  soc_bus_pkg::data_t ctrl_rdata_i,
  input  soc_bus_pkg::data_t rom_rdata_i,
  input  logic               rom_err_i,
  input  logic               uart_busy_i
);

  localparam int unsigned PtrWidth = (ReqQueueDepth > 1) ? $clog2(ReqQueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(ReqQueueDepth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  // Range check of an address against the memory map
  function automatic soc_map_pkg::soc_target_e decode_target(input soc_bus_pkg::addr_t addr);
    soc_map_pkg::soc_target_e tgt;
    tgt = soc_map_pkg::NONE;
    if (addr >= soc_map_pkg::DramBase &&
        addr < soc_map_pkg::DramBase + soc_map_pkg::DramLength) begin
      tgt = soc_map_pkg::L2MEM;
    end else if (addr >= soc_map_pkg::UartBase &&
                 addr < soc_map_pkg::UartBase + soc_map_pkg::UartLength) begin
      tgt = soc_map_pkg::UART;
    end else if (addr >= soc_map_pkg::CtrlBase &&
                 addr < soc_map_pkg::CtrlBase + soc_map_pkg::CtrlLength) begin
      tgt = soc_map_pkg::CTRL;
    end else if (addr >= soc_map_pkg::RomBase &&
                 addr < soc_map_pkg::RomBase + soc_map_pkg::RomLength) begin
      tgt = soc_map_pkg::ROM;
    end
    return tgt;
  endfunction

  function automatic ptr_t next_ptr(input ptr_t ptr);
    return (ptr == ptr_t'(ReqQueueDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Request queue
  //////////////////////////////////////////////////////////////////////

  logic                     q_we    [ReqQueueDepth];
  soc_bus_pkg::addr_t       q_addr  [ReqQueueDepth];
  soc_bus_pkg::data_t       q_wdata [ReqQueueDepth];
  soc_bus_pkg::strb_t       q_strb  [ReqQueueDepth];
  soc_map_pkg::soc_target_e q_tgt   [ReqQueueDepth];

  ptr_t wr_ptr_q, rd_ptr_q;
  cnt_t count_q;
  logic dispatch;

  soc_map_pkg::soc_target_e head_tgt;

  assign head_tgt = q_tgt[rd_ptr_q];

  // Head stalls while the UART is still sending
  assign dispatch = (count_q != '0) &&
                    !(head_tgt == soc_map_pkg::UART && uart_busy_i);

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      q_we[wr_ptr_q]    <= req_we_i;
      q_addr[wr_ptr_q]  <= req_addr_i;
      q_wdata[wr_ptr_q] <= req_wdata_i;
      q_strb[wr_ptr_q]  <= req_strb_i;
      q_tgt[wr_ptr_q]   <= decode_target(req_addr_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (dispatch) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + cnt_t'(req_valid_i) - cnt_t'(dispatch);
    end
  end

  // One credit back per dispatched slot
  assign credit_o = dispatch;

  //////////////////////////////////////////////////////////////////////
  // Dispatch to targets
  //////////////////////////////////////////////////////////////////////

  assign l2_sel_o   = dispatch && (head_tgt == soc_map_pkg::L2MEM);
  assign uart_sel_o = dispatch && (head_tgt == soc_map_pkg::UART);
  assign ctrl_sel_o = dispatch && (head_tgt == soc_map_pkg::CTRL);
  assign rom_sel_o  = dispatch && (head_tgt == soc_map_pkg::ROM);

  assign tgt_we_o    = q_we[rd_ptr_q];
  assign tgt_addr_o  = q_addr[rd_ptr_q];
  assign tgt_wdata_o = q_wdata[rd_ptr_q];
  assign tgt_strb_o  = q_strb[rd_ptr_q];

  //////////////////////////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////////////////////////

  logic                     rsp_valid_q;
  soc_map_pkg::soc_target_e rsp_tgt_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
      rsp_tgt_q   <= soc_map_pkg::NONE;
    end else begin
      rsp_valid_q <= dispatch;
      if (dispatch) begin
        rsp_tgt_q <= head_tgt;
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;

  // UART reads and unmapped accesses return zero data
  always_comb begin
    rsp_rdata_o = '0;
    rsp_err_o   = 1'b0;
    if (rsp_valid_q) begin
      case (rsp_tgt_q)
        soc_map_pkg::L2MEM: rsp_rdata_o = l2_rdata_i;
        soc_map_pkg::CTRL:  rsp_rdata_o = ctrl_rdata_i;
        soc_map_pkg::ROM: begin
          rsp_rdata_o = rom_rdata_i;
          rsp_err_o   = rom_err_i;
        end
        soc_map_pkg::NONE:  rsp_err_o = 1'b1;
        default: ;
      endcase
    end
  end

  // Master must respect its credits
  assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i |-> (count_q < cnt_t'(ReqQueueDepth)));

endmodule : soc_addr_decoder

//--- soc_l2_mem.sv
/*
 * L2 memory
 * Single-port word memory with byte strobes and one-cycle read data
 */

module soc_l2_mem #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               sel_i,
  input  logic               we_i,
  input  soc_bus_pkg::addr_t addr_i,
  input  soc_bus_pkg::data_t wdata_i,
  input  soc_bus_pkg::strb_t strb_i,
  output soc_bus_pkg::data_t rdata_o
);

  localparam int unsigned IdxBits = (L2NumWords > 1) ? $clog2(L2NumWords) : 1;

  typedef logic [IdxBits-1:0] idx_t;

  soc_bus_pkg::data_t mem [L2NumWords];
  soc_bus_pkg::data_t rdata_q;
  idx_t               word_idx;

  // Word index wraps around the memory size
  assign word_idx = idx_t'(addr_i[63:soc_bus_pkg::ByteOffsetBits] % L2NumWords);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (sel_i && we_i) begin
      for (int b = 0; b < soc_bus_pkg::StrbWidth; b++) begin
        if (strb_i[b]) begin
          mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read port, writes answer with zero
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_q <= '0;
    end else if (sel_i) begin
      rdata_q <= we_i ? '0 : mem[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule : soc_l2_mem

//--- soc_mock_uart.sv
/*
 * Mock UART
 * Emits the low byte of each write as a character, then stays busy for
 * a fixed number of cycles per character
 */

module soc_mock_uart #(
  parameter int unsigned UartCharCycles = 8
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    sel_i,
  input  logic                    we_i,
  input  soc_bus_pkg::data_t      wdata_i,
  output logic                    busy_o,
  output logic                    uart_valid_o,
  output soc_bus_pkg::uart_char_t uart_char_o
);

  localparam int unsigned CntWidth = $clog2(UartCharCycles + 1);

  typedef enum logic {
    IDLE,
    SENDING
  } uart_state_e;

  uart_state_e                state_q;
  logic [CntWidth-1:0]        cnt_q;
  logic                       valid_q;
  soc_bus_pkg::uart_char_t    char_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (sel_i && we_i) begin
            state_q <= SENDING;
            cnt_q   <= CntWidth'(UartCharCycles - 1);
            valid_q <= 1'b1;
          end
        end
        SENDING: begin
          // Busy for UartCharCycles cycles in total
          if (cnt_q == '0) begin
            state_q <= IDLE;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i && we_i) begin
      char_q <= wdata_i[7:0];
    end
  end

  assign busy_o       = (state_q == SENDING);
  assign uart_valid_o = valid_q;
  assign uart_char_o  = char_q;

  // Decoder holds UART requests back while a character is in flight
  assert property (@(posedge clk_i) disable iff (reset_i) sel_i |-> !busy_o);

endmodule : soc_mock_uart

//--- soc_ctrl_regs.sv
/*
 * Control registers
 * Exit code, event trigger and the read-only DRAM bounds
 */

module soc_ctrl_regs (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               sel_i,
  input  logic               we_i,
  input  soc_bus_pkg::addr_t addr_i,
  input  soc_bus_pkg::data_t wdata_i,
  output soc_bus_pkg::data_t rdata_o,
  output soc_bus_pkg::data_t exit_o,
  output logic               event_trigger_o
);

  //////////////////////////////////////////////////////////////////////
  // Register offsets
  //////////////////////////////////////////////////////////////////////

  localparam logic [11:0] ExitOffset     = 12'h000;
  localparam logic [11:0] EventOffset    = 12'h008;
  localparam logic [11:0] DramBaseOffset = 12'h010;
  localparam logic [11:0] DramEndOffset  = 12'h018;

  logic [11:0]        offset;
  soc_bus_pkg::data_t exit_q;
  logic               event_q;
  soc_bus_pkg::data_t rdata_q;
  soc_bus_pkg::data_t read_val;

  assign offset = addr_i[11:0];

  // Read mux
  always_comb begin
    case (offset)
      ExitOffset:     read_val = exit_q;
      DramBaseOffset: read_val = soc_map_pkg::DramBase;
      DramEndOffset:  read_val = soc_map_pkg::DramBase + soc_map_pkg::DramLength;
      default:        read_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_q  <= '0;
      event_q <= 1'b0;
    end else begin
      // Single-cycle pulse per trigger write
      event_q <= sel_i && we_i && (offset == EventOffset);
      if (sel_i && we_i && offset == ExitOffset) begin
        exit_q <= wdata_i;
      end
    end
  end

  // Write response carries zero data
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_q <= '0;
    end else if (sel_i) begin
      rdata_q <= we_i ? '0 : read_val;
    end
  end

  assign rdata_o         = rdata_q;
  assign exit_o          = exit_q;
  assign event_trigger_o = event_q;

endmodule : soc_ctrl_regs

//--- soc_boot_rom.sv
/*
 * Boot ROM
 * Sixteen fixed words of a NOP-like image, writes answer with an error
 */

module soc_boot_rom (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               sel_i,
  input  logic               we_i,
  input  soc_bus_pkg::addr_t addr_i,
  output soc_bus_pkg::data_t rdata_o,
  output logic               err_o
);

  logic [3:0]         rom_idx;
  soc_bus_pkg::data_t rom_word;
  soc_bus_pkg::data_t rdata_q;
  logic               err_q;

  assign rom_idx = addr_i[6:3];

  // Word i reads as 0x13 + i * 0x100
  assign rom_word = {52'd0, rom_idx, 8'h13};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else if (sel_i) begin
      rdata_q <= we_i ? '0 : rom_word;
      err_q   <= we_i;
    end
  end

  assign rdata_o = rdata_q;
  assign err_o   = err_q;

endmodule : soc_boot_rom

//--- ara_soc_sim.sv
/*
 * SoC simulation top
 * Address decoder driving the L2 memory, mock UART, control registers
 * and boot ROM from a single credited request bus
 */

module ara_soc_sim #(
  parameter int unsigned L2NumWords     = 1024,
  parameter int unsigned ReqQueueDepth  = 4,
  parameter int unsigned UartCharCycles = 8
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_valid_i,
  input  logic                    req_we_i,
  input  soc_bus_pkg::addr_t      req_addr_i,
  input  soc_bus_pkg::data_t      req_wdata_i,
  input  soc_bus_pkg::strb_t      req_strb_i,
  output logic                    credit_o,
  output logic                    rsp_valid_o,
  output soc_bus_pkg::data_t      rsp_rdata_o,
  output logic                    rsp_err_o,
  output soc_bus_pkg::data_t      exit_o,
  output logic                    event_trigger_o,
  output logic                    uart_valid_o,
  output soc_bus_pkg::uart_char_t uart_char_o
);

  logic               l2_sel, uart_sel, ctrl_sel, rom_sel;
  logic               tgt_we;
  soc_bus_pkg::addr_t tgt_addr;
  soc_bus_pkg::data_t tgt_wdata;
  soc_bus_pkg::strb_t tgt_strb;
  soc_bus_pkg::data_t l2_rdata, ctrl_rdata, rom_rdata;
  logic               rom_err;
  logic               uart_busy;

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  soc_addr_decoder #(
    .ReqQueueDepth(ReqQueueDepth)
  ) i_addr_decoder (
    .clk_i       (clk_i      ),
    .reset_i     (reset_i    ),
    .req_valid_i (req_valid_i),
    .req_we_i    (req_we_i   ),
    .req_addr_i  (req_addr_i ),
    .req_wdata_i (req_wdata_i),
    .req_strb_i  (req_strb_i ),
    .credit_o    (credit_o   ),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o  ),
    .l2_sel_o    (l2_sel     ),
    .uart_sel_o  (uart_sel   ),
    .ctrl_sel_o  (ctrl_sel   ),
    .rom_sel_o   (rom_sel    ),
    .tgt_we_o    (tgt_we     ),
    .tgt_addr_o  (tgt_addr   ),
    .tgt_wdata_o (tgt_wdata  ),
    .tgt_strb_o  (tgt_strb   ),
    .l2_rdata_i  (l2_rdata   ),
    .ctrl_rdata_i(ctrl_rdata ),
    .rom_rdata_i (rom_rdata  ),
    .rom_err_i   (rom_err    ),
    .uart_busy_i (uart_busy  )
  );

  //////////////////////////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////////////////////////

  soc_l2_mem #(
    .L2NumWords(L2NumWords)
  ) i_l2_mem (
    .clk_i  (clk_i    ),
    .reset_i(reset_i  ),
    .sel_i  (l2_sel   ),
    .we_i   (tgt_we   ),
    .addr_i (tgt_addr ),
    .wdata_i(tgt_wdata),
    .strb_i (tgt_strb ),
    .rdata_o(l2_rdata )
  );

  soc_mock_uart #(
    .UartCharCycles(UartCharCycles)
  ) i_mock_uart (
    .clk_i       (clk_i       ),
    .reset_i     (reset_i     ),
    .sel_i       (uart_sel    ),
    .we_i        (tgt_we      ),
    .wdata_i     (tgt_wdata   ),
    .busy_o      (uart_busy   ),
    .uart_valid_o(uart_valid_o),
    .uart_char_o (uart_char_o )
  );

  soc_ctrl_regs i_ctrl_regs (
    .clk_i          (clk_i          ),
    .reset_i        (reset_i        ),
    .sel_i          (ctrl_sel       ),
    .we_i           (tgt_we         ),
    .addr_i         (tgt_addr       ),
    .wdata_i        (tgt_wdata      ),
    .rdata_o        (ctrl_rdata     ),
    .exit_o         (exit_o         ),
    .event_trigger_o(event_trigger_o)
  );

  soc_boot_rom i_boot_rom (
    .clk_i  (clk_i    ),
    .reset_i(reset_i  ),
    .sel_i  (rom_sel  ),
    .we_i   (tgt_we   ),
    .addr_i (tgt_addr ),
    .rdata_o(rom_rdata),
    .err_o  (rom_err  )
  );

endmodule : ara_soc_sim

//--- tb_ara_soc_sim.sv
/*
 * Testbench for the SoC simulation top
 * Plays a request trace under credit flow control and checks responses,
 * control register side effects and UART characters
 */

module tb_ara_soc_sim;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned L2NumWords     = 1024;
  localparam int unsigned ReqQueueDepth  = 4;
  localparam int unsigned UartCharCycles = 8;
  localparam int          MaxEntries     = 64;
  localparam int          Fields         = 6;

  logic clk_i, reset_i;
  logic req_valid_i, req_we_i;
  soc_bus_pkg::addr_t req_addr_i;
  soc_bus_pkg::data_t req_wdata_i;
  soc_bus_pkg::strb_t req_strb_i;
  logic credit_o, rsp_valid_o, rsp_err_o, event_trigger_o, uart_valid_o;
  soc_bus_pkg::data_t rsp_rdata_o, exit_o;
  soc_bus_pkg::uart_char_t uart_char_o;

  logic [63:0] trace_mem [MaxEntries*Fields];
  soc_bus_pkg::data_t exp_rdata_q[$];
  logic exp_err_q[$];
  int exp_kind_q[$];  // 0 plain, 1 exit code write, 2 event trigger write
  soc_bus_pkg::data_t exp_exit_q[$];
  soc_bus_pkg::uart_char_t exp_char_q[$];

  int credits, value_errors, other_errors, num_entries, cycle_count, timeout_limit;
  integer seed = 32'hca43;

  ara_soc_sim #(
    .L2NumWords(L2NumWords),
    .ReqQueueDepth(ReqQueueDepth),
    .UartCharCycles(UartCharCycles)
  ) DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Advance one cycle and account for credits spent and returned
  task automatic wait_cycle();
    @(posedge clk_i);
    credits = credits + int'(credit_o) - int'(req_valid_i);
    assert (credits >= 0 && credits <= int'(ReqQueueDepth)) else begin
      $display("[ERROR] %0t credits: expected 0..%0d, got %0d", $time, ReqQueueDepth, credits);
      value_errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Response and UART checks
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    soc_bus_pkg::data_t e_rdata;
    logic e_err;
    int e_kind;
    soc_bus_pkg::data_t e_exit;
    logic e_event;
    e_event = 1'b0;
    if (!reset_i && rsp_valid_o) begin
      if (exp_rdata_q.size() == 0) begin
        $display("%0t: response arrived with no request outstanding", $time);
        other_errors++;
      end else begin
        e_rdata = exp_rdata_q.pop_front();
        e_err   = exp_err_q.pop_front();
        e_kind  = exp_kind_q.pop_front();
        e_exit  = exp_exit_q.pop_front();
        assert (rsp_rdata_o === e_rdata) else begin
          $display("[ERROR] %0t rsp_rdata_o: expected %h, got %h", $time, e_rdata, rsp_rdata_o);
          value_errors++;
        end
        assert (rsp_err_o === e_err) else begin
          $display("[ERROR] %0t rsp_err_o: expected %b, got %b", $time, e_err, rsp_err_o);
          value_errors++;
        end
        // Register side effects show in the response cycle
        if (e_kind == 1) begin
          assert (exit_o === e_exit) else begin
            $display("[ERROR] %0t exit_o: expected %h, got %h", $time, e_exit, exit_o);
            value_errors++;
          end
        end
        if (e_kind == 2) begin
          e_event = 1'b1;
        end
      end
    end
    // Trigger pulses only in the response cycle of its write
    if (!reset_i) begin
      assert (event_trigger_o === e_event) else begin
        $display("[ERROR] %0t event_trigger_o: expected %b, got %b",
                 $time, e_event, event_trigger_o);
        value_errors++;
      end
    end
  end

  always @(posedge clk_i) begin
    soc_bus_pkg::uart_char_t e_char;
    if (!reset_i && uart_valid_o) begin
      if (exp_char_q.size() == 0) begin
        $display("%0t: UART printed a character that was never written", $time);
        other_errors++;
      end else begin
        e_char = exp_char_q.pop_front();
        assert (uart_char_o === e_char) else begin
          $display("[ERROR] %0t uart_char_o: expected %h, got %h", $time, e_char, uart_char_o);
          value_errors++;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
      $display("Run did not finish within %0d cycles, %0d responses still outstanding",
               timeout_limit, exp_rdata_q.size());
      $display("Errors: %0d value, %0d other", value_errors, other_errors + 1);
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int gap;
    logic [63:0] addr;
    reset_i = 1'b1;
    req_valid_i = 1'b0;
    req_we_i = 1'b0;
    req_addr_i = '0;
    req_wdata_i = '0;
    req_strb_i = '0;
    credits = ReqQueueDepth;
    value_errors = 0;
    other_errors = 0;
    cycle_count = 0;
    timeout_limit = 0;
    $readmemh("ara_soc_sim_trace.txt", trace_mem);
    num_entries = 0;
    while (num_entries < MaxEntries && trace_mem[num_entries*Fields] != 64'd2) begin
      num_entries++;
    end
    timeout_limit = num_entries * (UartCharCycles + 4) + 100;

    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;

    for (int i = 0; i < num_entries; i++) begin
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) begin
        wait_cycle();
        req_valid_i <= 1'b0;
      end
      wait_cycle();
      while (credits == 0) begin
        req_valid_i <= 1'b0;
        wait_cycle();
      end
      addr = trace_mem[i*Fields+1];
      req_valid_i <= 1'b1;
      req_we_i    <= trace_mem[i*Fields][0];
      req_addr_i  <= addr;
      req_wdata_i <= trace_mem[i*Fields+2];
      req_strb_i  <= trace_mem[i*Fields+3][7:0];
      exp_rdata_q.push_back(trace_mem[i*Fields+4]);
      exp_err_q.push_back(trace_mem[i*Fields+5][0]);
      exp_exit_q.push_back(trace_mem[i*Fields+2]);
      if (trace_mem[i*Fields][0] && addr == soc_map_pkg::CtrlBase) begin
        exp_kind_q.push_back(1);
      end else if (trace_mem[i*Fields][0] && addr == soc_map_pkg::CtrlBase + 64'h8) begin
        exp_kind_q.push_back(2);
      end else begin
        exp_kind_q.push_back(0);
      end
      // Each UART write prints its low byte
      if (trace_mem[i*Fields][0] && addr >= soc_map_pkg::UartBase &&
          addr < soc_map_pkg::UartBase + soc_map_pkg::UartLength) begin
        exp_char_q.push_back(trace_mem[i*Fields+2][7:0]);
      end
    end
    wait_cycle();
    req_valid_i <= 1'b0;

    while (exp_rdata_q.size() != 0 || exp_char_q.size() != 0) begin
      wait_cycle();
    end
    wait_cycle();
    assert (credits == int'(ReqQueueDepth)) else begin
      $display("[ERROR] %0t credits: expected %0d, got %0d", $time, ReqQueueDepth, credits);
      value_errors++;
    end

    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : tb_ara_soc_sim

//--- ara_soc_sim.f
soc_bus_pkg.sv
soc_map_pkg.sv
soc_addr_decoder.sv
soc_l2_mem.sv
soc_mock_uart.sv
soc_ctrl_regs.sv
soc_boot_rom.sv
ara_soc_sim.sv
tb_ara_soc_sim.sv

//--- run_sim.sh
#!/bin/sh
# Build the SoC model with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_ara_soc_sim -f ara_soc_sim.f

output=$(./obj_dir/Vtb_ara_soc_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "All tests passed!"; then
  exit 0
fi
exit 1

//--- ara_soc_sim_trace.txt
// op addr wdata strb exp_rdata exp_err
// op is 0 for a read, 1 for a write and 2 for the end of the trace
1 80000000 1122334455667788 ff 0000000000000000 0
1 80000000 aaaaaaaaaaaaaaaa 0f 0000000000000000 0
0 80000000 0000000000000000 00 11223344aaaaaaaa 0
1 80000000 ffffffffffffffff 00 0000000000000000 0
0 80000000 0000000000000000 00 11223344aaaaaaaa 0
1 80000008 0000000000000000 ff 0000000000000000 0
1 80000008 deadbeefcafef00d 81 0000000000000000 0
0 80000008 0000000000000000 00 de0000000000000d 0
1 80001ff8 0123456789abcdef ff 0000000000000000 0
1 80001ff8 ffffffffffffffff 3c 0000000000000000 0
0 80001ff8 0000000000000000 00 0123ffffffffcdef 0
0 00010000 0000000000000000 00 0000000000000013 0
0 00010008 0000000000000000 00 0000000000000113 0
0 00010040 0000000000000000 00 0000000000000813 0
0 00010078 0000000000000000 00 0000000000000f13 0
1 00010000 1234567812345678 ff 0000000000000000 1
0 20000000 0000000000000000 00 0000000000000000 1
1 00000000 0000000000000001 ff 0000000000000000 1
0 d0000000 0000000000000000 00 0000000000000000 0
1 d0000000 00000000000000a5 ff 0000000000000000 0
0 d0000000 0000000000000000 00 00000000000000a5 0
0 d0000010 0000000000000000 00 0000000080000000 0
0 d0000018 0000000000000000 00 0000000080002000 0
1 d0000008 0000000000000001 ff 0000000000000000 0
0 d0000008 0000000000000000 00 0000000000000000 0
1 10000000 0000000000000048 ff 0000000000000000 0
1 10000000 0000000000000065 ff 0000000000000000 0
1 10000000 000000000000006c ff 0000000000000000 0
1 10000000 ffffffffffffff6c ff 0000000000000000 0
1 10000000 000000000000006f ff 0000000000000000 0
0 10000000 0000000000000000 00 0000000000000000 0
1 80000100 0f0e0d0c0b0a0908 ff 0000000000000000 0
1 10000000 0000000000000021 ff 0000000000000000 0
0 80000100 0000000000000000 00 0f0e0d0c0b0a0908 0
0 00010018 0000000000000000 00 0000000000000313 0
0 d0000000 0000000000000000 00 00000000000000a5 0
0 90000000 0000000000000000 00 0000000000000000 1
0 80000000 0000000000000000 00 11223344aaaaaaaa 0
2 0 0 0 0 0
